// File: project.f
rtl/rv_pkg.sv
rtl/sync_ram_dp.sv
rtl/regfile.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/riscv_core.sv
tb/tb_clock_gen.sv
tb/riscv_core_asserts.sv
tb/riscv_core_tb.sv

// File: rtl/decoder.sv
`timescale 1ns/1ns
`default_nettype none

module decoder (
    input  wire [rv_pkg::XLEN-1:0]          inst_i,
    output rv_pkg::opcode_e                 opcode_o,
    output logic [rv_pkg::REG_AWIDTH-1:0]   rs1_o,
    output logic [rv_pkg::REG_AWIDTH-1:0]   rs2_o,
    output logic [rv_pkg::REG_AWIDTH-1:0]   rd_o,
    output logic [rv_pkg::XLEN-1:0]         imm_o,
    output rv_pkg::alu_op_e                 alu_op_o,
    output logic                            alu_src_imm_o,
    output rv_pkg::wb_sel_e                 wb_sel_o,
    output logic                            reg_we_o,
    output logic [2:0]                      funct3_o,
    output logic                            csr_hit_o
);

    rv_pkg::opcode_e opcode;
    logic [2:0]      funct3;

    assign opcode = rv_pkg::opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];

    assign opcode_o = opcode;
    assign funct3_o = funct3;
    assign rs1_o    = inst_i[19:15];
    assign rs2_o    = inst_i[24:20];
    assign rd_o     = inst_i[11:7];

    // csrrw / csrrwi to the status register only
    assign csr_hit_o = (opcode == rv_pkg::SYSTEM) && (funct3[1:0] == 2'b01)
                       && (inst_i[31:20] == rv_pkg::CSR_STATUS_ADDR);

    always_comb begin
        case (opcode)
            rv_pkg::STORE:  imm_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            rv_pkg::BRANCH: imm_o = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                                     inst_i[30:25], inst_i[11:8], 1'b0};
            rv_pkg::LUI,
            rv_pkg::AUIPC:  imm_o = {inst_i[31:12], 12'b0};
            rv_pkg::JAL:    imm_o = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                                     inst_i[20], inst_i[30:21], 1'b0};
            rv_pkg::SYSTEM: imm_o = {27'b0, inst_i[19:15]};   // zimm for csrrwi
            default:        imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
        endcase
    end

    always_comb begin
        alu_op_o      = rv_pkg::ALU_ADD;
        alu_src_imm_o = 1'b1;
        wb_sel_o      = rv_pkg::WB_ALU;
        reg_we_o      = 1'b0;
        case (opcode)
            rv_pkg::OP, rv_pkg::OP_IMM: begin
                alu_src_imm_o = (opcode == rv_pkg::OP_IMM);
                reg_we_o      = 1'b1;
                case (funct3)
                    3'b000: alu_op_o = (opcode == rv_pkg::OP && inst_i[30]) ?
                                       rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001: alu_op_o = rv_pkg::ALU_SLL;
                    3'b010: alu_op_o = rv_pkg::ALU_SLT;
                    3'b011: alu_op_o = rv_pkg::ALU_SLTU;
                    3'b100: alu_op_o = rv_pkg::ALU_XOR;
                    3'b101: alu_op_o = inst_i[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110: alu_op_o = rv_pkg::ALU_OR;
                    default: alu_op_o = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::LUI: begin
                alu_op_o = rv_pkg::ALU_PASS_B;
                reg_we_o = 1'b1;
            end
            rv_pkg::AUIPC: reg_we_o = 1'b1;   // pc + imm, operand a picked in execute
            rv_pkg::LOAD: begin
                wb_sel_o = rv_pkg::WB_MEM;
                reg_we_o = 1'b1;
            end
            rv_pkg::JAL, rv_pkg::JALR: begin
                wb_sel_o = rv_pkg::WB_PC4;
                reg_we_o = 1'b1;
            end
            rv_pkg::BRANCH: alu_src_imm_o = 1'b0;
            default: ;   // store, system and unknown write no register
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  wire                             clk,
    input  wire                             rst_i,
    input  wire                             valid_i,
    input  wire [rv_pkg::XLEN-1:0]          pc_i,
    input  rv_pkg::opcode_e                 opcode_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]    rs1_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]    rs2_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]    rd_i,
    input  wire [rv_pkg::XLEN-1:0]          imm_i,
    input  rv_pkg::alu_op_e                 alu_op_i,
    input  wire                             alu_src_imm_i,
    input  rv_pkg::wb_sel_e                 wb_sel_i,
    input  wire                             reg_we_i,
    input  wire [2:0]                       funct3_i,
    input  wire                             csr_hit_i,
    input  wire [rv_pkg::XLEN-1:0]          rd1_i,
    input  wire [rv_pkg::XLEN-1:0]          rd2_i,
    input  wire                             fwd_we_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]    fwd_addr_i,
    input  wire [rv_pkg::XLEN-1:0]          fwd_data_i,
    output logic                            redirect_o,
    output logic [rv_pkg::XLEN-1:0]         target_o,
    output logic [rv_pkg::XLEN-1:0]         dmem_addr_o,
    output logic                            dmem_we_o,
    output logic [rv_pkg::XLEN-1:0]         dmem_wdata_o,
    output logic                            csr_we_o,
    output logic [rv_pkg::XLEN-1:0]         csr_wdata_o,
    output logic [rv_pkg::REG_AWIDTH-1:0]   wb_rd_o,
    output logic                            wb_we_o,
    output rv_pkg::wb_sel_e                 wb_sel_o,
    output logic [rv_pkg::XLEN-1:0]         wb_alu_o,
    output logic [rv_pkg::XLEN-1:0]         wb_pc4_o
);

    logic [rv_pkg::XLEN-1:0] op_a, op_b;     // forwarded register operands
    logic [rv_pkg::XLEN-1:0] alu_a, alu_b, alu_res, base;
    logic                    taken;

    assign op_a = (fwd_we_i && fwd_addr_i != '0 && fwd_addr_i == rs1_i) ? fwd_data_i : rd1_i;
    assign op_b = (fwd_we_i && fwd_addr_i != '0 && fwd_addr_i == rs2_i) ? fwd_data_i : rd2_i;

    assign alu_a = (opcode_i == rv_pkg::AUIPC) ? pc_i : op_a;
    assign alu_b = alu_src_imm_i ? imm_i : op_b;

    always_comb begin
        case (alu_op_i)
            rv_pkg::ALU_SUB:    alu_res = alu_a - alu_b;
            rv_pkg::ALU_SLL:    alu_res = alu_a << alu_b[4:0];
            rv_pkg::ALU_SLT:    alu_res = {31'b0, $signed(alu_a) < $signed(alu_b)};
            rv_pkg::ALU_SLTU:   alu_res = {31'b0, alu_a < alu_b};
            rv_pkg::ALU_XOR:    alu_res = alu_a ^ alu_b;
            rv_pkg::ALU_SRL:    alu_res = alu_a >> alu_b[4:0];
            rv_pkg::ALU_SRA:    alu_res = $signed(alu_a) >>> alu_b[4:0];
            rv_pkg::ALU_OR:     alu_res = alu_a | alu_b;
            rv_pkg::ALU_AND:    alu_res = alu_a & alu_b;
            rv_pkg::ALU_PASS_B: alu_res = alu_b;
            default:            alu_res = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (funct3_i)
            3'b000:  taken = (op_a == op_b);
            3'b001:  taken = (op_a != op_b);
            3'b100:  taken = $signed(op_a) < $signed(op_b);
            3'b101:  taken = $signed(op_a) >= $signed(op_b);
            3'b110:  taken = op_a < op_b;
            default: taken = op_a >= op_b;   // bgeu
        endcase
    end

    // jalr jumps from rs1, everything else from pc
    assign base     = (opcode_i == rv_pkg::JALR) ? op_a : pc_i;
    assign target_o = (base + imm_i) & ~32'd1;

    assign redirect_o = valid_i && ((opcode_i == rv_pkg::BRANCH && taken)
                                    || opcode_i == rv_pkg::JAL || opcode_i == rv_pkg::JALR);

    assign dmem_addr_o  = alu_res;
    assign dmem_wdata_o = op_b;
    assign dmem_we_o    = valid_i && (opcode_i == rv_pkg::STORE)
                          && alu_res[rv_pkg::DMEM_SEL_BIT];

    assign csr_we_o    = valid_i && csr_hit_i;
    assign csr_wdata_o = funct3_i[2] ? imm_i : op_a;   // csrrwi takes zimm

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= valid_i && reg_we_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o  <= rd_i;
        wb_sel_o <= wb_sel_i;
        wb_alu_o <= alu_res;
        wb_pc4_o <= pc_i + 32'd4;
    end

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire                         redirect_i,
    input  wire [rv_pkg::XLEN-1:0]      target_i,
    output logic [rv_pkg::XLEN-1:0]     imem_addr_o,
    output logic [rv_pkg::XLEN-1:0]     pc_o,
    output logic                        valid_o
);

    logic [rv_pkg::XLEN-1:0] fetch_pc_q;   // address being read from imem
    logic [rv_pkg::XLEN-1:0] pc_q;         // pc of the word now leaving imem
    logic [rv_pkg::XLEN-1:0] next_pc;
    logic                    valid_q;

    assign next_pc = redirect_i ? target_i : fetch_pc_q + 32'd4;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            fetch_pc_q <= RESET_PC;
            valid_q    <= 1'b0;
        end else begin
            fetch_pc_q <= next_pc;
            valid_q    <= ~redirect_i;   // word already in flight is wrong path
        end
    end

    always_ff @(posedge clk) begin
        pc_q <= fetch_pc_q;   // follows the imem read latency
    end

    assign imem_addr_o = fetch_pc_q;
    assign pc_o        = pc_q;
    assign valid_o     = valid_q;

endmodule

`default_nettype wire

// File: rtl/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  wire                             clk,
    input  wire [rv_pkg::REG_AWIDTH-1:0]    ra1_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]    ra2_i,
    output logic [rv_pkg::XLEN-1:0]         rd1_o,
    output logic [rv_pkg::XLEN-1:0]         rd2_o,
    input  wire [rv_pkg::REG_AWIDTH-1:0]    wa_i,
    input  wire                             we_i,
    input  wire [rv_pkg::XLEN-1:0]          wd_i
);

    logic [rv_pkg::XLEN-1:0] regs [0:(2**rv_pkg::REG_AWIDTH)-1];

    always_ff @(posedge clk) begin
        if (we_i) begin
            regs[wa_i] <= wd_i;
        end
    end

    // x0 always reads as zero
    assign rd1_o = (ra1_i == '0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : regs[ra2_i];

endmodule

`default_nettype wire

// File: rtl/riscv_core.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0,
    parameter int IMEM_AWIDTH = 10,
    parameter int DMEM_AWIDTH = 10
) (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire                         prog_we_i,
    input  wire [IMEM_AWIDTH-1:0]       prog_addr_i,
    input  wire [rv_pkg::XLEN-1:0]      prog_data_i,
    output logic [rv_pkg::XLEN-1:0]     csr_o
);

    logic [rv_pkg::XLEN-1:0]        imem_addr, pc, inst, target;
    logic                           inst_valid, redirect;
    rv_pkg::opcode_e                opcode;
    logic [rv_pkg::REG_AWIDTH-1:0]  rs1, rs2, rd;
    logic [rv_pkg::XLEN-1:0]        imm, rd1, rd2;
    rv_pkg::alu_op_e                alu_op;
    logic                           alu_src_imm, reg_we, csr_hit;
    rv_pkg::wb_sel_e                wb_sel;
    logic [2:0]                     funct3;
    logic [rv_pkg::XLEN-1:0]        dmem_addr, dmem_wdata, dmem_rdata;
    logic                           dmem_we;
    logic                           csr_we;
    logic [rv_pkg::XLEN-1:0]        csr_wdata, csr_q;
    logic [rv_pkg::REG_AWIDTH-1:0]  wb_rd, rf_wa;
    logic                           wb_we, rf_we;
    rv_pkg::wb_sel_e                wb_sel_q;
    logic [rv_pkg::XLEN-1:0]        wb_alu, wb_pc4, rf_wd;

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rst_i(rst_i),
        .redirect_i(redirect), .target_i(target),
        .imem_addr_o(imem_addr), .pc_o(pc), .valid_o(inst_valid)
    );

    // port b loads the program while the core sits in reset
    sync_ram_dp #(.AWIDTH(IMEM_AWIDTH)) u_imem (
        .clk(clk),
        .a_addr_i(imem_addr[IMEM_AWIDTH+1:2]), .a_we_i(1'b0), .a_din_i('0), .a_dout_o(inst),
        .b_addr_i(prog_addr_i), .b_we_i(prog_we_i), .b_din_i(prog_data_i)
    );

    decoder u_decoder (
        .inst_i(inst), .opcode_o(opcode),
        .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm),
        .alu_op_o(alu_op), .alu_src_imm_o(alu_src_imm), .wb_sel_o(wb_sel),
        .reg_we_o(reg_we), .funct3_o(funct3), .csr_hit_o(csr_hit)
    );

    regfile u_regfile (
        .clk(clk), .ra1_i(rs1), .ra2_i(rs2), .rd1_o(rd1), .rd2_o(rd2),
        .wa_i(rf_wa), .we_i(rf_we), .wd_i(rf_wd)
    );

    execute_stage u_execute (
        .clk(clk), .rst_i(rst_i), .valid_i(inst_valid), .pc_i(pc),
        .opcode_i(opcode), .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd), .imm_i(imm),
        .alu_op_i(alu_op), .alu_src_imm_i(alu_src_imm), .wb_sel_i(wb_sel),
        .reg_we_i(reg_we), .funct3_i(funct3), .csr_hit_i(csr_hit),
        .rd1_i(rd1), .rd2_i(rd2),
        .fwd_we_i(rf_we), .fwd_addr_i(rf_wa), .fwd_data_i(rf_wd),   // from writeback
        .redirect_o(redirect), .target_o(target),
        .dmem_addr_o(dmem_addr), .dmem_we_o(dmem_we), .dmem_wdata_o(dmem_wdata),
        .csr_we_o(csr_we), .csr_wdata_o(csr_wdata),
        .wb_rd_o(wb_rd), .wb_we_o(wb_we), .wb_sel_o(wb_sel_q),
        .wb_alu_o(wb_alu), .wb_pc4_o(wb_pc4)
    );

    sync_ram_dp #(.AWIDTH(DMEM_AWIDTH)) u_dmem (
        .clk(clk),
        .a_addr_i(dmem_addr[DMEM_AWIDTH+1:2]), .a_we_i(dmem_we),
        .a_din_i(dmem_wdata), .a_dout_o(dmem_rdata),
        .b_addr_i('0), .b_we_i(1'b0), .b_din_i('0)   // second port unused
    );

    writeback_stage u_writeback (
        .wb_rd_i(wb_rd), .wb_we_i(wb_we), .wb_sel_i(wb_sel_q),
        .wb_alu_i(wb_alu), .wb_pc4_i(wb_pc4), .dmem_rdata_i(dmem_rdata),
        .rf_wa_o(rf_wa), .rf_we_o(rf_we), .rf_wd_o(rf_wd)
    );

    always_ff @(posedge clk) begin
        if (rst_i) begin
            csr_q <= '0;
        end else if (csr_we) begin
            csr_q <= csr_wdata;   // status csr 0x51e
        end
    end

    assign csr_o = csr_q;

endmodule

`default_nettype wire

// File: rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_AWIDTH = 5;

    localparam logic [11:0] CSR_STATUS_ADDR = 12'h51e;  // status csr, drives csr_o
    localparam int unsigned DMEM_SEL_BIT    = 28;       // address bit that selects dmem

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10   // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2   // link value for jal/jalr
    } wb_sel_e;

endpackage

`default_nettype wire

// File: rtl/sync_ram_dp.sv
`timescale 1ns/1ns
`default_nettype none

module sync_ram_dp #(
    parameter int AWIDTH = 10
) (
    input  wire                      clk,
    input  wire [AWIDTH-1:0]         a_addr_i,
    input  wire                      a_we_i,
    input  wire [rv_pkg::XLEN-1:0]   a_din_i,
    output logic [rv_pkg::XLEN-1:0]  a_dout_o,
    input  wire [AWIDTH-1:0]         b_addr_i,
    input  wire                      b_we_i,
    input  wire [rv_pkg::XLEN-1:0]   b_din_i
);

    logic [rv_pkg::XLEN-1:0] mem [0:(2**AWIDTH)-1];

    always_ff @(posedge clk) begin
        if (b_we_i) begin
            mem[b_addr_i] <= b_din_i;   // program load / spare port
        end
        if (a_we_i) begin
            mem[a_addr_i] <= a_din_i;
        end
        a_dout_o <= mem[a_addr_i];      // read-first on port a
    end

endmodule

`default_nettype wire

// File: rtl/writeback_stage.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_stage (
    input  wire [rv_pkg::REG_AWIDTH-1:0]    wb_rd_i,
    input  wire                             wb_we_i,
    input  rv_pkg::wb_sel_e                 wb_sel_i,
    input  wire [rv_pkg::XLEN-1:0]          wb_alu_i,
    input  wire [rv_pkg::XLEN-1:0]          wb_pc4_i,
    input  wire [rv_pkg::XLEN-1:0]          dmem_rdata_i,
    output logic [rv_pkg::REG_AWIDTH-1:0]   rf_wa_o,
    output logic                            rf_we_o,
    output logic [rv_pkg::XLEN-1:0]         rf_wd_o
);

    always_comb begin
        case (wb_sel_i)
            rv_pkg::WB_MEM: rf_wd_o = dmem_rdata_i;   // word returned this cycle
            rv_pkg::WB_PC4: rf_wd_o = wb_pc4_i;
            default:        rf_wd_o = wb_alu_i;
        endcase
    end

    assign rf_wa_o = wb_rd_i;
    assign rf_we_o = wb_we_i && (wb_rd_i != '0);   // x0 writes dropped

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the riscv_core testbench with Verilator
verilator --binary --assert --timescale 1ns/1ns --top-module riscv_core_tb \
    -f project.f --Mdir obj_dir -o riscv_core_sim > build.log 2>&1 \
    && ./obj_dir/riscv_core_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

// File: tb/riscv_core_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_core_asserts (
    input  wire                             clk,
    input  wire                             rst_i,
    input  wire                             dmem_we_i,
    input  wire                             csr_we_i,
    input  wire                             rf_we_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]    rf_wa_i,
    input  wire [rv_pkg::XLEN-1:0]          imem_addr_i
);

    // a reset edge clears the fetch valid bit, so no side effect can follow
    reset_quiet: assert property (@(posedge clk) rst_i |=> (!dmem_we_i && !csr_we_i))
        else $error("dmem write or csr write active while the core is in reset");

    no_x0_write: assert property (@(posedge clk) disable iff (rst_i)
                                  rf_we_i |-> (rf_wa_i != '0))
        else $error("register file write aimed at x0");

    fetch_aligned: assert property (@(posedge clk) disable iff (rst_i)
                                    imem_addr_i[1:0] == 2'b00)
        else $error("fetch address is not word aligned");

endmodule

bind riscv_core riscv_core_asserts u_asserts (
    .clk(clk), .rst_i(rst_i), .dmem_we_i(dmem_we), .csr_we_i(csr_we),
    .rf_we_i(rf_we), .rf_wa_i(rf_wa), .imem_addr_i(imem_addr)
);

`default_nettype wire

// File: tb/riscv_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_core_tb;

    localparam int NUM_TESTS   = 8;
    localparam int PROG_WORDS  = 16;
    localparam int IMEM_AW     = 10;
    localparam int RUN_CYCLES  = 200;
    localparam int WATCHDOG_NS = NUM_TESTS * 220 * 10 * 2;

    localparam logic [31:0] NOP = 32'h0000_0013;   // addi x0, x0, 0

    logic                clk;
    logic                rst_i;
    logic                prog_we_i;
    logic [IMEM_AW-1:0]  prog_addr_i;
    logic [31:0]         prog_data_i;
    logic [31:0]         csr_o;

    string       test_name [NUM_TESTS];
    logic [31:0] prog_tbl  [NUM_TESTS][PROG_WORDS];
    logic [31:0] exp_csr   [NUM_TESTS];
    int          num_checks;
    int          num_errors;

    tb_clock_gen #(.PERIOD_NS(10)) u_clock (.clk_o(clk));

    riscv_core #(
        .RESET_PC(32'h0), .IMEM_AWIDTH(IMEM_AW), .DMEM_AWIDTH(10)
    ) DUT (
        .clk(clk), .rst_i(rst_i), .prog_we_i(prog_we_i),
        .prog_addr_i(prog_addr_i), .prog_data_i(prog_data_i), .csr_o(csr_o)
    );

    // RV32I instruction encoders
    function automatic logic [31:0] r_op(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] i_op(int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
    endfunction

    function automatic logic [31:0] lw(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'h03};
    endfunction

    function automatic logic [31:0] sw(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] br(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] lui(int rd, int imm20);
        return {imm20[19:0], rd[4:0], 7'h37};
    endfunction

    function automatic logic [31:0] auipc(int rd, int imm20);
        return {imm20[19:0], rd[4:0], 7'h17};
    endfunction

    function automatic logic [31:0] jal(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic logic [31:0] jalr(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h67};
    endfunction

    function automatic logic [31:0] csrw(int rs1);
        return {12'h51e, rs1[4:0], 3'b001, 5'd0, 7'h73};
    endfunction

    function automatic logic [31:0] csrwi(int zimm);
        return {12'h51e, zimm[4:0], 3'b101, 5'd0, 7'h73};
    endfunction

    task automatic build_table();
        test_name[0] = "alu_basic";
        exp_csr[0]   = 32'h0044_0102;
        prog_tbl[0]  = '{i_op(0, 1, 0, 100), i_op(0, 2, 0, -7), r_op(32, 0, 10, 1, 2),
                         i_op(4, 3, 2, 'hf0), r_op(0, 0, 10, 10, 3), i_op(5, 3, 2, 'h401),
                         r_op(0, 4, 10, 10, 3), i_op(5, 3, 2, 28), r_op(0, 1, 10, 10, 3),
                         r_op(0, 3, 3, 1, 2), r_op(0, 2, 4, 2, 3), r_op(0, 0, 4, 4, 3),
                         r_op(0, 6, 10, 10, 4), i_op(6, 10, 10, 'h100), csrw(10), jal(0, 0)};
        test_name[1] = "alu_shift_logic";
        exp_csr[1]   = 32'h7800_0402;
        prog_tbl[1]  = '{lui(1, 'h80000), i_op(0, 2, 0, 5), r_op(32, 5, 3, 1, 2),
                         r_op(0, 5, 4, 1, 2), r_op(0, 4, 10, 3, 4), i_op(1, 5, 2, 8),
                         r_op(0, 6, 10, 10, 5), i_op(7, 10, 10, -1024), i_op(2, 6, 1, 0),
                         i_op(3, 7, 2, -1), r_op(0, 0, 6, 6, 7), r_op(0, 0, 10, 10, 6),
                         r_op(0, 7, 8, 1, 3), r_op(0, 4, 10, 10, 8), csrw(10), jal(0, 0)};
        test_name[2] = "forward_chain";
        exp_csr[2]   = 32'h0000_0026;
        prog_tbl[2]  = '{i_op(0, 1, 0, 1), r_op(0, 0, 1, 1, 1), r_op(0, 0, 1, 1, 1),
                         i_op(0, 2, 1, 3), r_op(0, 0, 1, 1, 2), r_op(32, 0, 3, 2, 1),
                         r_op(0, 0, 3, 3, 3), r_op(32, 0, 4, 0, 3), r_op(0, 0, 5, 4, 1),
                         r_op(0, 0, 5, 5, 5), csrw(5), jal(0, 0), NOP, NOP, NOP, NOP};
        test_name[3] = "store_load";
        exp_csr[3]   = 32'hdb97_530f;
        prog_tbl[3]  = '{lui(5, 'h10000), lui(1, 'h12345), i_op(0, 1, 1, 'h678), sw(1, 5, 8),
                         lw(2, 5, 8), i_op(0, 3, 0, -1), sw(3, 5, 12), lw(4, 5, 12),
                         r_op(0, 4, 10, 2, 4), lw(6, 5, 8), r_op(32, 0, 10, 10, 6), csrw(10),
                         jal(0, 0), NOP, NOP, NOP};
        // each branch skips an add of one bit, so the sum names the not-taken ones
        test_name[4] = "branch_a";
        exp_csr[4]   = 32'h0000_002a;
        prog_tbl[4]  = '{i_op(0, 1, 0, -1), i_op(0, 10, 0, 0),
                         br(0, 1, 1, 8), i_op(0, 10, 10, 1), br(1, 1, 1, 8), i_op(0, 10, 10, 2),
                         br(4, 1, 0, 8), i_op(0, 10, 10, 4), br(5, 1, 0, 8), i_op(0, 10, 10, 8),
                         br(6, 0, 1, 8), i_op(0, 10, 10, 16), br(7, 0, 1, 8), i_op(0, 10, 10, 32),
                         csrw(10), jal(0, 0)};
        test_name[5] = "branch_b";
        exp_csr[5]   = 32'h0000_0015;
        prog_tbl[5]  = '{i_op(0, 1, 0, -1), i_op(0, 10, 0, 0),
                         br(0, 1, 0, 8), i_op(0, 10, 10, 1), br(1, 1, 0, 8), i_op(0, 10, 10, 2),
                         br(4, 0, 1, 8), i_op(0, 10, 10, 4), br(5, 0, 1, 8), i_op(0, 10, 10, 8),
                         br(6, 1, 0, 8), i_op(0, 10, 10, 16), br(7, 1, 0, 8), i_op(0, 10, 10, 32),
                         csrw(10), jal(0, 0)};
        test_name[6] = "jump_link";
        exp_csr[6]   = 32'h0000_0024;
        prog_tbl[6]  = '{jal(1, 12), i_op(0, 1, 0, 0), i_op(0, 1, 0, 0), auipc(2, 0),
                         jalr(3, 2, 16), i_op(0, 3, 0, 0), i_op(0, 3, 0, 0), r_op(0, 0, 10, 1, 3),
                         r_op(0, 0, 10, 10, 2), csrw(10), jal(0, 0), NOP, NOP, NOP, NOP, NOP};
        test_name[7] = "x0_csrwi";
        exp_csr[7]   = 32'h0000_001b;
        prog_tbl[7]  = '{i_op(0, 0, 0, 5), lui(0, 'hfffff), r_op(0, 0, 10, 0, 0), br(1, 10, 0, 12),
                         csrwi(27), jal(0, 0), csrw(10), jal(0, 0), NOP, NOP, NOP, NOP,
                         NOP, NOP, NOP, NOP};
    endtask

    initial begin
        rst_i       = 1'b1;
        prog_we_i   = 1'b0;
        prog_addr_i = '0;
        prog_data_i = '0;
        num_checks  = 0;
        num_errors  = 0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk);
            rst_i = 1'b1;
            for (int w = 0; w < PROG_WORDS; w++) begin
                prog_we_i   = 1'b1;
                prog_addr_i = w[IMEM_AW-1:0];
                prog_data_i = prog_tbl[t][w];
                @(negedge clk);
            end
            prog_we_i = 1'b0;
            repeat (5) @(negedge clk);   // reset tail after the load
            rst_i = 1'b0;
            repeat (RUN_CYCLES) @(negedge clk);
            num_checks++;
            if (csr_o !== exp_csr[t]) begin
                num_errors++;
                $display("Error: %s expected %08h actual %08h", test_name[t], exp_csr[t], csr_o);
            end
        end
        $display("checks run: %0d, errors: %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before all programs ran", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 10
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;   // 50% duty
    end

endmodule

`default_nettype wire
